// ==== tenyr_pkg.sv ====
`default_nettype none

package tenyr_pkg;

    // One access on the operand bus
    typedef struct packed {
        logic        rw;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    // One-hot target strobes from the decoder
    typedef struct packed {
        logic ram;
        logic seg7;
        logic video_ctl;
        logic crx;
        logic cry;
        logic text;
    } bus_sel_t;

    // Address map in word addresses
    localparam int unsigned RAM_WORDS  = 256;
    localparam logic [31:0] SEG7_ADDR  = 32'h0000_0100;
    localparam logic [31:0] VIDEO_ADDR = 32'h0001_0000;
    localparam logic [31:0] TEXT_BASE  = VIDEO_ADDR + 32'h10;

    // Text screen geometry
    localparam int unsigned TEXT_COLS  = 80;
    localparam int unsigned TEXT_ROWS  = 40;
    localparam int unsigned TEXT_WORDS = TEXT_COLS * TEXT_ROWS;
    localparam int unsigned TEXT_AW    = 12;

    // Video register reset values
    localparam logic [7:0] VIDEO_CTL_DEFAULT = 8'b1111_0111;
    localparam logic [7:0] CRX_DEFAULT       = 8'd1;
    localparam logic [7:0] CRY_DEFAULT       = 8'd0;

    // Clock cycles each display digit stays lit
    localparam int unsigned SEG7_DIV = 16;

    // Active-low hex font with bit order {dp, g, f, e, d, c, b, a}
    function automatic logic [7:0] hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'hc0;
            4'h1: return 8'hf9;
            4'h2: return 8'ha4;
            4'h3: return 8'hb0;
            4'h4: return 8'h99;
            4'h5: return 8'h92;
            4'h6: return 8'h82;
            4'h7: return 8'hf8;
            4'h8: return 8'h80;
            4'h9: return 8'h90;
            4'ha: return 8'h88;
            4'hb: return 8'h83;
            4'hc: return 8'hc6;
            4'hd: return 8'ha1;
            4'he: return 8'h86;
            default: return 8'h8e;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== mmr.sv ====
`default_nettype none

module mmr #(
    parameter int unsigned      WIDTH   = 8,
    parameter logic [WIDTH-1:0] DEFAULT = '0
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             sel,
    input  logic             rw,
    input  logic [31:0]      wdata,
    output logic [WIDTH-1:0] val,
    output logic [31:0]      rdata
);

    always_ff @(posedge clk) begin
        if (rst) begin
            val <= DEFAULT;
        end else if (sel && rw) begin
            val <= wdata[WIDTH-1:0];
        end
    end

    // Readback is zero-extended to the bus width
    always_ff @(posedge clk) begin
        if (sel && !rw) begin
            rdata <= 32'(val);
        end
    end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`default_nettype none

module data_ram (
    input  logic        clk,
    input  logic        sel,
    input  logic        rw,
    input  logic [7:0]  addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata
);
    import tenyr_pkg::*;

    logic [31:0] mem [RAM_WORDS];

    // One write or one registered read per cycle
    always_ff @(posedge clk) begin
        if (sel) begin
            if (rw) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== seg7.sv ====
`default_nettype none

module seg7 (
    input  logic        clk,
    input  logic        rst,
    input  logic        sel,
    input  logic        rw,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic [7:0]  seg,
    output logic [3:0]  an
);
    import tenyr_pkg::*;

    localparam int unsigned DIV_W = $clog2(SEG7_DIV);

    logic [15:0]      value;
    logic [DIV_W-1:0] presc;
    logic [1:0]       digit;
    logic [3:0]       nib;

    // Display value written from the bus
    always_ff @(posedge clk) begin
        if (rst) begin
            value <= '0;
        end else if (sel && rw) begin
            value <= wdata[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !rw) begin
            rdata <= 32'(value);
        end
    end

    // Prescaler sets how long each digit stays lit
    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
            digit <= '0;
        end else if (presc == DIV_W'(SEG7_DIV - 1)) begin
            presc <= '0;
            digit <= digit + 2'd1;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Digit 0 shows the lowest nibble
    always_comb begin
        case (digit)
            2'd0:    nib = value[3:0];
            2'd1:    nib = value[7:4];
            2'd2:    nib = value[11:8];
            default: nib = value[15:12];
        endcase
    end

    assign seg = hex_seg(nib);
    assign an  = ~(4'b0001 << digit);

endmodule

`default_nettype wire

// ==== text_ram.sv ====
`default_nettype none

module text_ram (
    input  logic                          clk,
    input  logic                          sel,
    input  logic                          rw,
    input  logic [tenyr_pkg::TEXT_AW-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [31:0]                   rdata,
    input  logic [tenyr_pkg::TEXT_AW-1:0] disp_addr,
    output logic [7:0]                    disp_data
);
    import tenyr_pkg::*;

    logic [7:0] mem [TEXT_WORDS];

    // Bus port
    always_ff @(posedge clk) begin
        if (sel) begin
            if (rw) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= 32'(mem[addr]);
            end
        end
    end

    // Display port reads every cycle
    always_ff @(posedge clk) begin
        disp_data <= mem[disp_addr];
    end

endmodule

`default_nettype wire

// ==== operand_bus.sv ====
`default_nettype none

module operand_bus (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [31:0]           addr,
    input  logic                  rw,
    output tenyr_pkg::bus_sel_t   sel,
    input  logic [31:0]           ram_rdata,
    input  logic [31:0]           seg7_rdata,
    input  logic [31:0]           video_ctl_rdata,
    input  logic [31:0]           crx_rdata,
    input  logic [31:0]           cry_rdata,
    input  logic [31:0]           text_rdata,
    output logic [31:0]           rdata
);
    import tenyr_pkg::*;

    bus_sel_t    sel_q;
    logic        rd_q;
    logic [31:0] rd_word;
    logic [31:0] rdata_q;

    // Address decode sets at most one strobe
    always_comb begin
        sel           = '0;
        sel.ram       = addr < RAM_WORDS;
        sel.seg7      = addr == SEG7_ADDR;
        sel.video_ctl = addr == VIDEO_ADDR;
        sel.crx       = addr == VIDEO_ADDR + 32'd1;
        sel.cry       = addr == VIDEO_ADDR + 32'd2;
        sel.text      = (addr >= TEXT_BASE) && (addr < TEXT_BASE + TEXT_WORDS);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= '0;
            rd_q  <= 1'b0;
        end else begin
            sel_q <= sel;
            rd_q  <= !rw;
        end
    end

    // Unselected targets contribute zero
    assign rd_word = ({32{sel_q.ram}}       & ram_rdata)
                   | ({32{sel_q.seg7}}      & seg7_rdata)
                   | ({32{sel_q.video_ctl}} & video_ctl_rdata)
                   | ({32{sel_q.crx}}       & crx_rdata)
                   | ({32{sel_q.cry}}       & cry_rdata)
                   | ({32{sel_q.text}}      & text_rdata);

    // Last read result survives write cycles
    assign rdata = rd_q ? rd_word : rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_q <= '0;
        end else begin
            rdata_q <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== tenyr_soc.sv ====
`default_nettype none

module tenyr_soc (
    input  logic                            clk,
    input  logic                            rst,
    input  tenyr_pkg::bus_req_t             req,
    output logic [31:0]                     rdata,
    input  logic [tenyr_pkg::TEXT_AW-1:0]   text_addr,
    output logic [7:0]                      text_data,
    output logic [7:0]                      video_ctl,
    output logic [7:0]                      crx,
    output logic [7:0]                      cry,
    output logic [7:0]                      seg,
    output logic [3:0]                      an
);
    import tenyr_pkg::*;

    bus_sel_t             sel;
    logic [31:0]          ram_rdata;
    logic [31:0]          seg7_rdata;
    logic [31:0]          video_ctl_rdata;
    logic [31:0]          crx_rdata;
    logic [31:0]          cry_rdata;
    logic [31:0]          text_rdata;
    logic [TEXT_AW-1:0]   text_idx;

    // Text RAM index relative to its base
    assign text_idx = TEXT_AW'(req.addr - TEXT_BASE);

    operand_bus operand_bus_i (
        .clk             (clk),
        .rst             (rst),
        .addr            (req.addr),
        .rw              (req.rw),
        .sel             (sel),
        .ram_rdata       (ram_rdata),
        .seg7_rdata      (seg7_rdata),
        .video_ctl_rdata (video_ctl_rdata),
        .crx_rdata       (crx_rdata),
        .cry_rdata       (cry_rdata),
        .text_rdata      (text_rdata),
        .rdata           (rdata)
    );

    data_ram data_ram_i (
        .clk   (clk),
        .sel   (sel.ram),
        .rw    (req.rw),
        .addr  (req.addr[7:0]),
        .wdata (req.wdata),
        .rdata (ram_rdata)
    );

    seg7 seg7_i (
        .clk   (clk),
        .rst   (rst),
        .sel   (sel.seg7),
        .rw    (req.rw),
        .wdata (req.wdata),
        .rdata (seg7_rdata),
        .seg   (seg),
        .an    (an)
    );

    mmr #(.WIDTH(8), .DEFAULT(VIDEO_CTL_DEFAULT)) video_ctl_mmr (
        .clk   (clk),
        .rst   (rst),
        .sel   (sel.video_ctl),
        .rw    (req.rw),
        .wdata (req.wdata),
        .val   (video_ctl),
        .rdata (video_ctl_rdata)
    );

    mmr #(.WIDTH(8), .DEFAULT(CRX_DEFAULT)) crx_mmr (
        .clk   (clk),
        .rst   (rst),
        .sel   (sel.crx),
        .rw    (req.rw),
        .wdata (req.wdata),
        .val   (crx),
        .rdata (crx_rdata)
    );

    mmr #(.WIDTH(8), .DEFAULT(CRY_DEFAULT)) cry_mmr (
        .clk   (clk),
        .rst   (rst),
        .sel   (sel.cry),
        .rw    (req.rw),
        .wdata (req.wdata),
        .val   (cry),
        .rdata (cry_rdata)
    );

    text_ram text_ram_i (
        .clk       (clk),
        .sel       (sel.text),
        .rw        (req.rw),
        .addr      (text_idx),
        .wdata     (req.wdata[7:0]),
        .rdata     (text_rdata),
        .disp_addr (text_addr),
        .disp_data (text_data)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half period of 2 gives a period of 4
    always begin
        #2 clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tenyr_soc_assertions.sv ====
`default_nettype none

module tenyr_soc_assertions (
    input logic                clk,
    input logic                rst,
    input tenyr_pkg::bus_req_t req,
    input logic [31:0]         rdata,
    input logic [3:0]          an
);

    int fail_count = 0;

    // Exactly one active-low digit driven
    an_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(~an))
        else begin
            fail_count++;
            $error("anode pattern is not one-hot low: %b", an);
        end

    rdata_after_reset: assert property (@(posedge clk) $fell(rst) |-> rdata == 32'h0)
        else begin
            fail_count++;
            $error("rdata not zero in the first cycle after reset");
        end

    // A write cycle keeps the previous read result
    write_holds_rdata: assert property (@(posedge clk) disable iff (rst)
        req.rw |=> $stable(rdata))
        else begin
            fail_count++;
            $error("rdata changed after a write cycle");
        end

endmodule

bind tenyr_soc tenyr_soc_assertions tenyr_soc_assertions_i (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .rdata (rdata),
    .an    (an)
);

`default_nettype wire

// ==== tenyr_soc_tb.sv ====
`default_nettype none

module tenyr_soc_tb;
    import tenyr_pkg::*;

    typedef struct packed {
        logic        rw;
        logic        chk;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
    } step_t;

    localparam int SCAN_LIMIT = 3 * SEG7_DIV;

    logic               clk;
    logic               rst;
    bus_req_t           req;
    logic [31:0]        rdata;
    logic [TEXT_AW-1:0] text_addr;
    logic [7:0]         text_data;
    logic [7:0]         video_ctl;
    logic [7:0]         crx;
    logic [7:0]         cry;
    logic [7:0]         seg;
    logic [3:0]         an;

    step_t       tbl[$];
    logic [31:0] ram_model [RAM_WORDS];
    int          seed;
    int          errors;
    int          checks;
    int          afails;
    logic [31:0] word;
    logic [15:0] seg_val;
    logic [7:0]  vc_val;
    logic [7:0]  crx_val;
    logic [7:0]  cry_val;
    int          text_idx [6] = '{0, 1, 79, 80, 1234, 3199};
    logic [7:0]  text_chr [6];

    tb_clock tb_clock_i (.clk(clk));

    tenyr_soc tenyr_soc_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rdata     (rdata),
        .text_addr (text_addr),
        .text_data (text_data),
        .video_ctl (video_ctl),
        .crx       (crx),
        .cry       (cry),
        .seg       (seg),
        .an        (an)
    );

    // Lit segments {g,f,e,d,c,b,a} per hex digit get inverted for the active-low pins
    function automatic logic [7:0] font(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~{1'b0, lit};
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic add_step(input logic rw, input logic chk, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp);
        step_t s;
        s.rw    = rw;
        s.chk   = chk;
        s.addr  = addr;
        s.wdata = wdata;
        s.exp   = exp;
        tbl.push_back(s);
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    // Each read is checked one cycle after it is issued
    task automatic run_table;
        for (int i = 0; i <= tbl.size(); i++) begin
            next_cycle();
            if (i > 0 && !tbl[i-1].rw && tbl[i-1].chk) begin
                compare($sformatf("rdata[%h]", tbl[i-1].addr), tbl[i-1].exp, rdata);
            end
            if (i < tbl.size()) begin
                req.rw    = tbl[i].rw;
                req.addr  = tbl[i].addr;
                req.wdata = tbl[i].wdata;
            end else begin
                // Idle as a write to an unmapped address
                req.rw    = 1'b1;
                req.addr  = 32'h200;
                req.wdata = '0;
            end
        end
    endtask

    task automatic scan_display;
        logic [3:0] prev_an;
        logic [3:0] seen;
        logic       changed;
        int         d;
        int         zeros;
        prev_an = an;
        seen    = '0;
        for (int k = 0; k < 4; k++) begin
            changed = 1'b0;
            for (int n = 0; n < SCAN_LIMIT && !changed; n++) begin
                next_cycle();
                changed = (an != prev_an);
            end
            if (!changed) begin
                errors++;
                $display("Timeout: digit anode did not advance within %0d cycles", SCAN_LIMIT);
                return;
            end
            prev_an = an;
            d       = 0;
            zeros   = 0;
            for (int j = 0; j < 4; j++) begin
                if (!an[j]) begin
                    d = j;
                    zeros++;
                end
            end
            if (zeros != 1) begin
                errors++;
                $display("Anode pattern %b does not select exactly one digit", an);
            end else begin
                compare($sformatf("seg digit %0d", d), font(seg_val[4*d +: 4]), seg);
                seen[d] = 1'b1;
            end
        end
        if (seen != 4'hf) begin
            errors++;
            $display("Only digits %b were seen within four scan periods", seen);
        end
    endtask

    initial begin
        seed      = 21;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        req.rw    = 1'b1;
        req.addr  = 32'h200;
        req.wdata = '0;
        text_addr = '0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        compare("video_ctl", VIDEO_CTL_DEFAULT, video_ctl);
        compare("crx", CRX_DEFAULT, crx);
        compare("cry", CRY_DEFAULT, cry);
        compare("rdata", 32'h0, rdata);

        add_step(1'b0, 1'b1, SEG7_ADDR, '0, 32'h0);
        add_step(1'b0, 1'b1, VIDEO_ADDR, '0, 32'(VIDEO_CTL_DEFAULT));
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i] = $random(seed);
            add_step(1'b1, 1'b0, 32'(i), ram_model[i], '0);
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            add_step(1'b0, 1'b1, 32'(i), '0, ram_model[i]);
        end
        add_step(1'b0, 1'b1, 32'h200, '0, 32'h0);

        word   = $random(seed);
        vc_val = word[7:0];
        add_step(1'b1, 1'b0, VIDEO_ADDR, word, '0);
        word    = $random(seed);
        crx_val = word[7:0];
        add_step(1'b1, 1'b0, VIDEO_ADDR + 32'd1, word, '0);
        word    = $random(seed);
        cry_val = word[7:0];
        add_step(1'b1, 1'b0, VIDEO_ADDR + 32'd2, word, '0);
        add_step(1'b0, 1'b1, VIDEO_ADDR, '0, {24'b0, vc_val});
        add_step(1'b0, 1'b1, VIDEO_ADDR + 32'd1, '0, {24'b0, crx_val});
        add_step(1'b0, 1'b1, VIDEO_ADDR + 32'd2, '0, {24'b0, cry_val});

        for (int k = 0; k < 6; k++) begin
            word        = $random(seed);
            text_chr[k] = word[7:0];
            add_step(1'b1, 1'b0, TEXT_BASE + 32'(text_idx[k]), word, '0);
        end
        for (int k = 0; k < 6; k++) begin
            add_step(1'b0, 1'b1, TEXT_BASE + 32'(text_idx[k]), '0, {24'b0, text_chr[k]});
        end
        // One past the last text cell is unmapped
        add_step(1'b0, 1'b1, TEXT_BASE + TEXT_WORDS, '0, 32'h0);

        word    = $random(seed);
        seg_val = word[15:0];
        add_step(1'b1, 1'b0, SEG7_ADDR, word, '0);
        add_step(1'b0, 1'b1, SEG7_ADDR, '0, {16'b0, seg_val});

        run_table();

        compare("video_ctl", vc_val, video_ctl);
        compare("crx", crx_val, crx);
        compare("cry", cry_val, cry);

        for (int k = 0; k < 6; k++) begin
            text_addr = TEXT_AW'(text_idx[k]);
            next_cycle();
            compare($sformatf("text_data[%0d]", text_idx[k]), text_chr[k], text_data);
        end

        scan_display();

        afails = tenyr_soc_i.tenyr_soc_assertions_i.fail_count;
        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
tenyr_pkg.sv
mmr.sv
data_ram.sv
seg7.sv
text_ram.sv
operand_bus.sv
tenyr_soc.sv
tb_clock.sv
tenyr_soc_assertions.sv
tenyr_soc_tb.sv

// ==== Bender.yml ====
package:
  name: tenyr_soc

sources:
  - tenyr_pkg.sv
  - mmr.sv
  - data_ram.sv
  - seg7.sv
  - text_ram.sv
  - operand_bus.sv
  - tenyr_soc.sv
  - target: simulation
    files:
      - tb_clock.sv
      - tenyr_soc_assertions.sv
      - tenyr_soc_tb.sv
